// File: hw/motion_macros.svh
// Motion controller constants
`ifndef MOTION_MACROS_SVH
`define MOTION_MACROS_SVH

// Host word and DDA datapath
`define WORD_BITS 64
`define DDA_BITS 64
`define DURATION_BITS 32

// Axes and move queue
`define NUM_AXES 2
`define MOVE_SLOTS 2

// Tick divider
`define DIVISOR_BITS 8
`define DEFAULT_DIVISOR 8'd32  // Ticks every 32 clocks out of reset

// API version bytes, reported low to high as patch, minor, major, devel
`define VERSION_MAJOR 8'd1
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd0
`define VERSION_DEVEL 8'd0

`endif

// File: hw/motion_cmd_pkg.sv
// Host command encodings
`include "motion_macros.svh"

package motion_cmd_pkg;

  // Opcode lives in the top byte of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0A,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_API_VERSION      = 8'hFE
  } cmd_opcode_e;

  // Header word as seen on the host bus
  typedef struct packed {
    cmd_opcode_e               opcode;
    logic [`WORD_BITS-9:0]     body;  // Arguments of single-word commands
  } word_header_t;

endpackage

// File: hw/motion_move_pkg.sv
// Move record types
`include "motion_macros.svh"

package motion_move_pkg;

  // Per-axis velocity and acceleration, both in DDA units per tick
  typedef struct packed {
    logic signed [`DDA_BITS-1:0] rate;
    logic signed [`DDA_BITS-1:0] rate_delta;  // Added to rate after every tick
  } axis_rate_t;

  // One buffered coordinated move
  typedef struct packed {
    logic [`DURATION_BITS-1:0]   duration;  // Length in ticks
    logic [`NUM_AXES-1:0]        dir;
    axis_rate_t [`NUM_AXES-1:0]  axis;
  } move_record_t;

  typedef logic [$clog2(`MOVE_SLOTS)-1:0] slot_index_t;

endpackage

// File: hw/word_cmd_decoder.sv
// Host word command decoder
`include "motion_macros.svh"

module word_cmd_decoder
  import motion_cmd_pkg::*;
  import motion_move_pkg::*;
(
  input  logic                      CLK,
  input  logic                      resetn,
  input  word_header_t              word_in,
  input  logic                      word_strobe,
  output logic [`WORD_BITS-1:0]     word_reply,
  output logic [`NUM_AXES-1:0]      enable,
  output logic [`DIVISOR_BITS-1:0]  divisor,
  output logic                      commit,
  output move_record_t              move_out
);

  // Header, duration, then rate and rate change per axis
  localparam int MOVE_WORDS = 2 + 2 * `NUM_AXES;
  localparam int COUNT_BITS = $clog2(MOVE_WORDS);

  typedef logic [COUNT_BITS-1:0] count_t;

  logic         strobe_q;
  logic         strobe_qq;
  logic         strobe_rise;
  word_header_t word_q;
  logic         move_pending;  // Header of a move seen, body words still due
  count_t       word_count;

  // Strobe edge detection
  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_q  <= 1'b0;
      strobe_qq <= 1'b0;
    end else begin
      strobe_q  <= word_strobe;
      strobe_qq <= strobe_q;
    end
  end

  // Word sampled together with the strobe
  always_ff @(posedge CLK) begin
    word_q <= word_in;
  end

  assign strobe_rise = strobe_q & ~strobe_qq;

  // Command state and configuration registers
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_reply   <= '0;
      enable       <= '0;
      divisor      <= `DEFAULT_DIVISOR;
      commit       <= 1'b0;
      move_pending <= 1'b0;
      word_count   <= '0;
    end else begin
      commit <= 1'b0;
      if (strobe_rise) begin
        word_reply <= '0;  // Zero unless a readback fills it
        if (!move_pending) begin
          case (word_q.opcode)
            CMD_COORDINATED_STEP: begin
              move_pending <= 1'b1;
              word_count   <= count_t'(1);
            end
            CMD_MOTOR_ENABLE: enable <= word_q.body[`NUM_AXES-1:0];
            CMD_CLK_DIVISOR:  divisor <= word_q.body[`DIVISOR_BITS-1:0];
            CMD_API_VERSION: begin
              word_reply <= {{(`WORD_BITS - 32){1'b0}}, `VERSION_DEVEL, `VERSION_MAJOR,
                             `VERSION_MINOR, `VERSION_PATCH};
            end
            default: ;  // Unknown opcodes are ignored
          endcase
        end else begin
          word_count <= word_count + 1'b1;
          // Last rate change word completes the record
          if (word_count == count_t'(MOVE_WORDS - 1)) begin
            commit       <= 1'b1;
            move_pending <= 1'b0;
            word_count   <= '0;
          end
        end
      end
    end
  end

  // Move record assembly
  always_ff @(posedge CLK) begin
    if (strobe_rise) begin
      if (!move_pending) begin
        if (word_q.opcode == CMD_COORDINATED_STEP) begin
          move_out.dir <= word_q.body[`NUM_AXES-1:0];
        end
      end else if (word_count == count_t'(1)) begin
        move_out.duration <= word_q.body[`DURATION_BITS-1:0];
      end else begin
        for (int a = 0; a < `NUM_AXES; a++) begin
          if (word_count == count_t'(2 * a + 2)) begin
            move_out.axis[a].rate <= word_q;
          end
          if (word_count == count_t'(2 * a + 3)) begin
            move_out.axis[a].rate_delta <= word_q;
          end
        end
      end
    end
  end

endmodule

// File: hw/move_buffer.sv
// Move record queue
`include "motion_macros.svh"

module move_buffer
  import motion_move_pkg::*;
(
  input  logic          CLK,
  input  logic          resetn,
  input  logic          commit,
  input  move_record_t  move_in,
  input  logic          release_head,
  output logic          head_valid,
  output move_record_t  head,
  output logic          buffer_dtr
);

  move_record_t           slots [`MOVE_SLOTS];
  slot_index_t            wr_idx;
  slot_index_t            rd_idx;
  logic [`MOVE_SLOTS-1:0] ready;  // Slot holds a move not yet executed

  function automatic slot_index_t next_index(slot_index_t idx);
    return (idx == slot_index_t'(`MOVE_SLOTS - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx <= '0;
      rd_idx <= '0;
      ready  <= '0;
    end else begin
      if (commit) begin
        ready[wr_idx] <= 1'b1;
        wr_idx        <= next_index(wr_idx);
      end
      if (release_head) begin
        ready[rd_idx] <= 1'b0;
        rd_idx        <= next_index(rd_idx);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (commit) slots[wr_idx] <= move_in;
  end

  assign head_valid = ready[rd_idx];
  assign head       = slots[rd_idx];
  assign buffer_dtr = ~&ready;  // Room for at least one more move

endmodule

// File: hw/dda_sequencer.sv
// DDA tick and move sequencer
`include "motion_macros.svh"

module dda_sequencer (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic [`DIVISOR_BITS-1:0]   divisor,
  input  logic                       head_valid,
  input  logic [`DURATION_BITS-1:0]  duration,
  output logic                       tick,
  output logic                       load,
  output logic                       running,
  output logic                       release_head,
  output logic                       move_done
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN,
    SEQ_DONE
  } seq_state_e;

  seq_state_e                state;
  logic [`DIVISOR_BITS-1:0]  div_cnt;
  logic [`DURATION_BITS-1:0] tick_cnt;  // Ticks already executed in this move
  logic                      last_tick;

  // Divider restarts on load so a move spans whole tick periods
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt <= '0;
    end else if (load || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign tick = (div_cnt >= divisor - 1'b1);

  // Zero duration also ends on the first tick
  assign last_tick = ({1'b0, tick_cnt} + 1'b1) >= {1'b0, duration};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state    <= SEQ_IDLE;
      tick_cnt <= '0;
    end else begin
      case (state)
        SEQ_IDLE: if (head_valid) state <= SEQ_LOAD;
        SEQ_LOAD: begin
          tick_cnt <= '0;
          state    <= SEQ_RUN;
        end
        SEQ_RUN: begin
          if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (last_tick) state <= SEQ_DONE;
          end
        end
        SEQ_DONE: state <= SEQ_IDLE;  // Next head is visible one cycle after release
        default:  state <= SEQ_IDLE;
      endcase
    end
  end

  assign load         = (state == SEQ_LOAD);
  assign running      = (state == SEQ_RUN);
  assign release_head = (state == SEQ_DONE);
  assign move_done    = (state == SEQ_DONE);

endmodule

// File: hw/dda_axis.sv
// Single axis DDA step generator
`include "motion_macros.svh"

module dda_axis
  import motion_move_pkg::*;
(
  input  logic       CLK,
  input  logic       resetn,
  input  logic       tick,
  input  logic       load,
  input  logic       running,
  input  axis_rate_t rate_in,
  output logic       step
);

  logic [`DDA_BITS-1:0]        acc;
  logic [`DDA_BITS-1:0]        acc_next;
  logic signed [`DDA_BITS-1:0] rate;
  logic signed [`DDA_BITS-1:0] rate_delta;

  assign acc_next = acc + rate;

  // Step when the accumulator crosses into its upper half
  assign step = tick & running & ~acc[`DDA_BITS-1] & acc_next[`DDA_BITS-1];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      acc <= '0;
    end else if (load) begin
      acc <= '0;
    end else if (tick && running) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      rate       <= rate_in.rate;
      rate_delta <= rate_in.rate_delta;
    end else if (tick && running) begin
      rate <= rate + rate_delta;  // Acceleration applied after the add
    end
  end

endmodule

// File: hw/stepper_motion_top.sv
// Stepper motion controller top
`include "motion_macros.svh"

module stepper_motion_top
  import motion_move_pkg::*;
(
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic [`WORD_BITS-1:0]  word_in,
  input  logic                   word_strobe,
  output logic [`WORD_BITS-1:0]  word_reply,
  output logic [`NUM_AXES-1:0]   step,
  output logic [`NUM_AXES-1:0]   dir,
  output logic [`NUM_AXES-1:0]   enable,
  output logic                   move_done,
  output logic                   buffer_dtr
);

  logic [`DIVISOR_BITS-1:0] divisor;
  logic                     commit;
  move_record_t             move_rec;  // Record being committed by the decoder
  move_record_t             head;      // Move executing or next to execute
  logic                     head_valid;
  logic                     release_head;
  logic                     tick;
  logic                     load;
  logic                     running;

  word_cmd_decoder u_decoder (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .word_reply  (word_reply),
    .enable      (enable),
    .divisor     (divisor),
    .commit      (commit),
    .move_out    (move_rec)
  );

  move_buffer u_buffer (
    .CLK          (CLK),
    .resetn       (resetn),
    .commit       (commit),
    .move_in      (move_rec),
    .release_head (release_head),
    .head_valid   (head_valid),
    .head         (head),
    .buffer_dtr   (buffer_dtr)
  );

  dda_sequencer u_sequencer (
    .CLK          (CLK),
    .resetn       (resetn),
    .divisor      (divisor),
    .head_valid   (head_valid),
    .duration     (head.duration),
    .tick         (tick),
    .load         (load),
    .running      (running),
    .release_head (release_head),
    .move_done    (move_done)
  );

  assign dir = head.dir;

  for (genvar i = 0; i < `NUM_AXES; i++) begin : g_axis
    dda_axis u_axis (
      .CLK     (CLK),
      .resetn  (resetn),
      .tick    (tick),
      .load    (load),
      .running (running),
      .rate_in (head.axis[i]),
      .step    (step[i])
    );
  end

endmodule

// File: dv/tb_clock.sv
// Testbench clock and reset
module tb_clock (
  output logic CLK,
  output logic resetn
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;  // Period of 8
  end

  initial begin
    resetn = 1'b1;
    repeat (3) @(posedge CLK);
    #1 resetn = 1'b0;  // Released just after the third edge
  end

endmodule

// File: dv/stepper_motion_tb.sv
// Stepper motion controller testbench
`include "motion_macros.svh"

module stepper_motion_tb;

  logic                  CLK;
  logic                  resetn;
  logic [`WORD_BITS-1:0] word_in;
  logic                  word_strobe;
  logic [`WORD_BITS-1:0] word_reply;
  logic [`NUM_AXES-1:0]  step;
  logic [`NUM_AXES-1:0]  dir;
  logic [`NUM_AXES-1:0]  enable;
  logic                  move_done;
  logic                  buffer_dtr;

  int unsigned           cyc;
  int                    step_cnt [`NUM_AXES];
  int unsigned           done_cyc [$];  // One entry per move_done pulse
  int                    done_s0 [$];
  int                    done_s1 [$];
  logic [`NUM_AXES-1:0]  done_dir [$];
  int unsigned           edge_cyc;      // Cycle at which the last word edge was sampled
  logic [`WORD_BITS-1:0] last_reply;
  logic [`NUM_AXES-1:0]  last_enable;
  int unsigned           limit_cycles;

  tb_clock u_clock (
    .CLK    (CLK),
    .resetn (resetn)
  );

  stepper_motion_top DUT (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .word_reply  (word_reply),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .move_done   (move_done),
    .buffer_dtr  (buffer_dtr)
  );

  always @(posedge CLK) cyc <= cyc + 1;

  // Step totals per move are closed by each move_done pulse
  always @(negedge CLK) begin
    for (int a = 0; a < `NUM_AXES; a++) begin
      if (step[a] === 1'b1) step_cnt[a]++;
    end
    if (move_done === 1'b1) begin
      done_cyc.push_back(cyc);
      done_dir.push_back(dir);
      done_s0.push_back(step_cnt[0]);
      done_s1.push_back(step_cnt[1]);
      for (int a = 0; a < `NUM_AXES; a++) step_cnt[a] = 0;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    $display("Timeout: the run took longer than %0d cycles", limit_cycles);
    $display("Finished with errors");
    $fatal(1);
  end

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("ERR at %0t: %s", $time, what);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // Called 1 unit after a rising edge and returns at the same phase
  task automatic send_word(input logic [`WORD_BITS-1:0] w);
    int gap;
    gap = $urandom_range(4, 1);
    word_in     = w;
    word_strobe = 1'b1;
    @(posedge CLK);
    #1 word_strobe = 1'b0;
    @(negedge CLK);
    edge_cyc = cyc;
    @(posedge CLK);
    @(negedge CLK);
    last_reply  = word_reply;  // Two cycles after the edge
    last_enable = enable;
    repeat (gap) @(posedge CLK);
    #1;
  endtask

  initial begin
    int fd;
    string line;
    string lines [$];
    string rest;
    byte tag;
    logic [`WORD_BITS-1:0] val;
    int dur;
    int exp_cyc;
    int n0;
    int n1;
    int exp_dir;
    int unsigned ticks;
    int unsigned got_cyc;

    word_in     = '0;
    word_strobe = 1'b0;
    cyc         = 0;
    ticks       = 0;
    for (int a = 0; a < `NUM_AXES; a++) step_cnt[a] = 0;
    void'($urandom(69468));

    fd = $fopen("dv/stepper_motion_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/stepper_motion_golden.txt");
      $display("Finished with errors");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 2 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);

    // Watchdog budget from the move lengths
    foreach (lines[i]) begin
      if (lines[i].getc(0) == "S") begin
        void'($sscanf(lines[i].substr(2, lines[i].len() - 1), "%d", dur));
        ticks += (dur == 0) ? 1 : dur;
      end
    end
    limit_cycles = ticks * `DEFAULT_DIVISOR * 4 + 2000;

    wait (resetn === 1'b1);
    wait (resetn === 1'b0);
    repeat (16) begin
      @(negedge CLK);
      check_true(enable === '0, "enable not zero after reset");
      check_true(move_done === 1'b0, "move_done high after reset");
      check_true(buffer_dtr === 1'b1, "buffer_dtr low after reset");
      check_true(step === '0, "step pulse after reset");
    end
    @(posedge CLK);
    #1;

    foreach (lines[i]) begin
      tag  = lines[i].getc(0);
      rest = lines[i].substr(2, lines[i].len() - 1);
      case (tag)
        "W": begin
          void'($sscanf(rest, "%h", val));
          send_word(val);
        end
        "R": begin
          void'($sscanf(rest, "%h", val));
          check_true(last_reply === val,
                     $sformatf("reply %h, expected %h", last_reply, val));
        end
        "E": begin
          void'($sscanf(rest, "%h", val));
          check_true(last_enable === val[`NUM_AXES-1:0],
                     $sformatf("enable %b, expected %b", last_enable, val[`NUM_AXES-1:0]));
        end
        "F": begin
          void'($sscanf(rest, "%h", val));
          check_true(buffer_dtr === val[0],
                     $sformatf("buffer_dtr %b, expected %b", buffer_dtr, val[0]));
        end
        "S": begin
          void'($sscanf(rest, "%d %d %d %d %d", dur, exp_cyc, n0, n1, exp_dir));
          while (done_cyc.size() == 0) @(negedge CLK);
          got_cyc = done_cyc.pop_front();
          if (exp_cyc != 0) begin
            check_true(got_cyc - edge_cyc == exp_cyc,
                       $sformatf("move_done after %0d cycles, expected %0d",
                                 got_cyc - edge_cyc, exp_cyc));
          end
          check_true(done_s0.pop_front() == n0, $sformatf("axis 0 step count, expected %0d", n0));
          check_true(done_s1.pop_front() == n1, $sformatf("axis 1 step count, expected %0d", n1));
          check_true(done_dir.pop_front() == exp_dir[`NUM_AXES-1:0],
                     $sformatf("dir wrong, expected %0d", exp_dir));
          @(posedge CLK);
          #1;
        end
        default: begin
          $display("Unknown line in golden file: %s", lines[i]);
          $display("Finished with errors");
          $fatal(1);
        end
      endcase
    end

    repeat (4) @(posedge CLK);
    check_true(done_cyc.size() == 0, "extra move_done pulse");
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: stepper_motion_top.f
+incdir+hw
hw/motion_cmd_pkg.sv
hw/motion_move_pkg.sv
hw/word_cmd_decoder.sv
hw/move_buffer.sv
hw/dda_sequencer.sv
hw/dda_axis.sv
hw/stepper_motion_top.sv
dv/tb_clock.sv
dv/stepper_motion_tb.sv

// File: Makefile
TB_TOP  = stepper_motion_tb
RTL_TOP = stepper_motion_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f stepper_motion_top.f --top-module $(TB_TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall +incdir+hw hw/motion_cmd_pkg.sv hw/motion_move_pkg.sv \
		hw/word_cmd_decoder.sv hw/move_buffer.sv hw/dda_sequencer.sv hw/dda_axis.sv \
		hw/stepper_motion_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir sim.log

// File: dv/stepper_motion_golden.txt
# W word (hex), R reply (hex), E enable (hex), F buffer_dtr (hex)
# S ticks done_cycles(0 skips) steps0 steps1 dir, decimal, done_cycles counted from last edge
W FE00000000000000
R 0000000000010300
W 0A00000000000002
E 2
W 0A00000000000003
E 3
W 2000000000000004
W 0100000000000002
W 000000000000000A
W 4000000000000000
W 0000000000000000
W 2000000000000000
W 0000000000000000
S 10 44 3 1 2
W 0100000000000001
W 0000000000000008
W 0000000000000000
W 1000000000000000
W 4000000000000000
W F000000000000000
S 8 36 2 1 1
F 1
W 0100000000000003
W 0000000000000014
W 4000000000000000
W 0000000000000000
W 8000000000000000
W 0000000000000000
F 1
W 0100000000000000
W 0000000000000000
W 8000000000000000
W 0000000000000000
W 0000000000000000
W 0000000000000000
F 0
S 20 0 5 10 3
S 0 0 1 0 0
